//--- common/intc_config.svh
`ifndef INTC_CONFIG_SVH
`define INTC_CONFIG_SVH

// Width of one event code.
`define INTC_DATA_W 8

// Number of priority levels, one queue each.
`define INTC_LEVELS 8

// Width of a level number.
`define INTC_PRI_W 3

// Entries per queue. Must be a power of two.
`define INTC_DEPTH 8

// Width of the occupancy count, which holds 0 up to the full depth.
`define INTC_CNT_W 4

// Saturating drop counter width.
`define INTC_DROP_W 8

`endif

//--- common/intc_pkg.sv
`default_nettype none

`include "intc_config.svh"

package intc_pkg;

    // One event code as posted by a device.
    typedef logic [`INTC_DATA_W-1:0] data_t;

    // One priority level, 0 lowest.
    typedef logic [`INTC_PRI_W-1:0] pri_t;

    // One bit per level.
    typedef logic [`INTC_LEVELS-1:0] level_vec_t;

endpackage

`default_nettype wire

//--- verilog/post_router.sv
`timescale 1ns/10ps
`default_nettype none

`include "intc_config.svh"

module post_router import intc_pkg::*; (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    post,
    input  wire pri_t                    post_pri,
    input  wire data_t                   post_data,
    input  wire level_vec_t              full,
    output level_vec_t                   push,
    output data_t                        push_data,
    output logic                         overflow,
    output logic [`INTC_DROP_W-1:0]      drop_count
);

    level_vec_t sel;
    logic       drop;

    // One-hot level select for the posted event.
    always_comb begin
        sel = '0;
        sel[post_pri] = post;
    end

    // A full queue refuses its push and the event is lost.
    assign push      = sel & ~full;
    assign push_data = post_data;
    assign drop      = post && full[post_pri];

    always_ff @(posedge clk) begin
        if (rst) begin
            overflow   <= 1'b0;
            drop_count <= '0;
        end else begin
            overflow <= drop;
            // Counter sticks at all ones.
            if (drop && (drop_count != '1)) begin
                drop_count <= drop_count + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- prio_queue/prio_queue.sv
`timescale 1ns/10ps
`default_nettype none

`include "intc_config.svh"

module prio_queue import intc_pkg::*; (
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  push,
    input  wire logic  pop,
    input  wire data_t push_data,
    output data_t      head_data,
    output logic       not_empty,
    output logic       full
);

    localparam int ptr_w = $clog2(`INTC_DEPTH);
    localparam logic [`INTC_CNT_W-1:0] depth_cnt = `INTC_DEPTH;

    data_t                   mem [`INTC_DEPTH];
    logic [ptr_w-1:0]        wr_ptr;
    logic [ptr_w-1:0]        rd_ptr;
    logic [`INTC_CNT_W-1:0]  count;
    logic                    at_cap;
    logic                    do_push;
    logic                    do_pop;

    assign at_cap    = (count == depth_cnt);
    assign not_empty = (count != '0);

    // A pop in this cycle frees a slot for a push in the same cycle.
    assign full = at_cap && !pop;

    assign do_push = push && !full;
    assign do_pop  = pop && not_empty;

    // The oldest entry always sits on the output.
    assign head_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/priority_dispatcher.sv
`timescale 1ns/10ps
`default_nettype none

`include "intc_config.svh"

module priority_dispatcher import intc_pkg::*; (
    input  wire logic                         clk,
    input  wire logic                         rst,
    input  wire logic                         read,
    input  wire level_vec_t                   not_empty,
    input  wire data_t [`INTC_LEVELS-1:0]     head_data,
    output level_vec_t                        pop,
    output logic                              pending,
    output pri_t                              pending_pri,
    output logic                              out_valid,
    output data_t                             out_data,
    output pri_t                              out_pri
);

    pri_t top_pri;
    logic take;

    // The last hit in the scan is the highest level.
    always_comb begin
        top_pri = '0;
        for (int i = 0; i < `INTC_LEVELS; i++) begin
            if (not_empty[i]) begin
                top_pri = pri_t'(i);
            end
        end
    end

    assign pending     = |not_empty;
    assign pending_pri = top_pri;

    // Reads with nothing pending are ignored.
    assign take = read && pending;

    always_comb begin
        pop = '0;
        pop[top_pri] = take;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= take;
        end
    end

    // The popped event is held for the cycle after the read.
    always_ff @(posedge clk) begin
        if (take) begin
            out_data <= head_data[top_pri];
            out_pri  <= top_pri;
        end
    end

endmodule

`default_nettype wire

//--- verilog/interrupt_controller.sv
`timescale 1ns/10ps
`default_nettype none

`include "intc_config.svh"

module interrupt_controller import intc_pkg::*; (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    post,
    input  wire pri_t                    post_pri,
    input  wire data_t                   post_data,
    input  wire logic                    read,
    output logic                         pending,
    output pri_t                         pending_pri,
    output logic                         out_valid,
    output data_t                        out_data,
    output pri_t                         out_pri,
    output logic                         overflow,
    output logic [`INTC_DROP_W-1:0]      drop_count
);

    level_vec_t                  push;
    level_vec_t                  pop;
    level_vec_t                  full;
    level_vec_t                  not_empty;
    data_t                       push_data;
    data_t [`INTC_LEVELS-1:0]    head_data;

    post_router post_router_inst (
        .clk        (clk),
        .rst        (rst),
        .post       (post),
        .post_pri   (post_pri),
        .post_data  (post_data),
        .full       (full),
        .push       (push),
        .push_data  (push_data),
        .overflow   (overflow),
        .drop_count (drop_count)
    );

    // One queue per level.
    for (genvar i = 0; i < `INTC_LEVELS; i++) begin : queue_gen
        prio_queue prio_queue_inst (
            .clk       (clk),
            .rst       (rst),
            .push      (push[i]),
            .pop       (pop[i]),
            .push_data (push_data),
            .head_data (head_data[i]),
            .not_empty (not_empty[i]),
            .full      (full[i])
        );
    end

    priority_dispatcher priority_dispatcher_inst (
        .clk         (clk),
        .rst         (rst),
        .read        (read),
        .not_empty   (not_empty),
        .head_data   (head_data),
        .pop         (pop),
        .pending     (pending),
        .pending_pri (pending_pri),
        .out_valid   (out_valid),
        .out_data    (out_data),
        .out_pri     (out_pri)
    );

endmodule

`default_nettype wire

//--- verification/intc_checker.sv
`timescale 1ns/10ps
`default_nettype none

`include "intc_config.svh"

module intc_checker import intc_pkg::*; (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire logic                     post,
    input  wire pri_t                     post_pri,
    input  wire data_t                    post_data,
    input  wire logic                     read,
    input  wire logic                     pending,
    input  wire pri_t                     pending_pri,
    input  wire logic                     out_valid,
    input  wire data_t                    out_data,
    input  wire pri_t                     out_pri,
    input  wire logic                     overflow,
    input  wire logic [`INTC_DROP_W-1:0]  drop_count,
    output int                            errors,
    output level_vec_t                    levels_read,
    output int                            drops_seen
);

    localparam int drop_max = (1 << `INTC_DROP_W) - 1;

    data_t model_mem [`INTC_LEVELS][`INTC_DEPTH];
    int    model_cnt [`INTC_LEVELS];
    int    model_rd [`INTC_LEVELS];
    int    model_drop;
    logic  exp_valid;
    logic  exp_overflow;
    data_t exp_data;
    pri_t  exp_pri;
    logic  armed;

    initial begin
        errors = 0;
        armed  = 1'b0;
    end

    // Highest level holding an event, or -1 when all are empty.
    function automatic int top_level();
        for (int i = `INTC_LEVELS - 1; i >= 0; i--) begin
            if (model_cnt[i] > 0) begin
                return i;
            end
        end
        return -1;
    endfunction

    task automatic compare_field(input string name, input logic [31:0] expv,
                                 input logic [31:0] actv);
        if (actv !== expv) begin
            errors++;
            $display("MISMATCH %s expected 0x%0h actual 0x%0h at %0t", name, expv, actv, $time);
        end
    endtask

    always @(posedge clk) begin
        int lvl;
        int slot;
        if (rst) begin
            for (int i = 0; i < `INTC_LEVELS; i++) begin
                model_cnt[i] = 0;
                model_rd[i]  = 0;
            end
            model_drop   = 0;
            exp_valid    = 1'b0;
            exp_overflow = 1'b0;
            levels_read  = '0;
            drops_seen   = 0;
            armed        = 1'b1;
        end else begin
            exp_valid    = 1'b0;
            exp_overflow = 1'b0;
            // Read first, against the queues as they stood before this edge.
            lvl = top_level();
            if (read && lvl >= 0) begin
                exp_valid        = 1'b1;
                exp_data         = model_mem[lvl][model_rd[lvl]];
                exp_pri          = pri_t'(lvl);
                model_rd[lvl]    = (model_rd[lvl] + 1) % `INTC_DEPTH;
                model_cnt[lvl]   = model_cnt[lvl] - 1;
                levels_read[lvl] = 1'b1;
            end
            if (post) begin
                lvl = int'(post_pri);
                if (model_cnt[lvl] == `INTC_DEPTH) begin
                    exp_overflow = 1'b1;
                    drops_seen++;
                    if (model_drop < drop_max) begin
                        model_drop++;
                    end
                end else begin
                    slot = (model_rd[lvl] + model_cnt[lvl]) % `INTC_DEPTH;
                    model_mem[lvl][slot] = post_data;
                    model_cnt[lvl]       = model_cnt[lvl] + 1;
                end
            end
        end
    end

    // Outputs are settled by the falling edge.
    always @(negedge clk) begin
        int lvl;
        if (armed && !rst) begin
            lvl = top_level();
            compare_field("pending", (lvl >= 0), pending);
            compare_field("pending_pri", (lvl >= 0) ? lvl : 0, pending_pri);
            compare_field("out_valid", exp_valid, out_valid);
            if (exp_valid && out_valid) begin
                compare_field("out_data", exp_data, out_data);
                compare_field("out_pri", exp_pri, out_pri);
            end
            compare_field("overflow", exp_overflow, overflow);
            compare_field("drop_count", model_drop, drop_count);
        end
    end

endmodule

`default_nettype wire

//--- verification/intc_assert.sv
`timescale 1ns/10ps
`default_nettype none

module intc_assert import intc_pkg::*; (
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       post,
    input  wire logic       read,
    input  wire logic       pending,
    input  wire logic       out_valid,
    input  wire logic       overflow,
    input  wire level_vec_t pop,
    input  wire level_vec_t not_empty
);

    int fail_count;

    initial fail_count = 0;

    valid_after_read: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> $past(read && pending))
        else begin
            fail_count++;
            $error("out_valid rose without a read while an event was pending");
        end

    overflow_after_post: assert property (@(posedge clk) disable iff (rst)
        overflow |-> $past(post))
        else begin
            fail_count++;
            $error("overflow rose without a post in the previous cycle");
        end

    // A pop must always land on a level that holds an event.
    pop_not_empty: assert property (@(posedge clk) disable iff (rst)
        (pop & ~not_empty) == '0)
        else begin
            fail_count++;
            $error("pop raised for an empty level");
        end

endmodule

bind interrupt_controller intc_assert intc_assert_inst (
    .clk       (clk),
    .rst       (rst),
    .post      (post),
    .read      (read),
    .pending   (pending),
    .out_valid (out_valid),
    .overflow  (overflow),
    .pop       (pop),
    .not_empty (not_empty)
);

`default_nettype wire

//--- verification/intc_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "intc_config.svh"

module intc_tb import intc_pkg::*; ();

    localparam int run_cycles  = 2000;
    localparam int drain_limit = `INTC_LEVELS * `INTC_DEPTH + 10;

    logic                     clk;
    logic                     rst;
    logic                     post;
    pri_t                     post_pri;
    data_t                    post_data;
    logic                     read;
    logic                     pending;
    pri_t                     pending_pri;
    logic                     out_valid;
    data_t                    out_data;
    pri_t                     out_pri;
    logic                     overflow;
    logic [`INTC_DROP_W-1:0]  drop_count;

    int         mismatch_errors;
    level_vec_t levels_read;
    int         drops_seen;
    int         timeout_errors;
    int         coverage_errors;

    interrupt_controller interrupt_controller_inst (
        .clk         (clk),
        .rst         (rst),
        .post        (post),
        .post_pri    (post_pri),
        .post_data   (post_data),
        .read        (read),
        .pending     (pending),
        .pending_pri (pending_pri),
        .out_valid   (out_valid),
        .out_data    (out_data),
        .out_pri     (out_pri),
        .overflow    (overflow),
        .drop_count  (drop_count)
    );

    intc_checker intc_checker_inst (
        .clk         (clk),
        .rst         (rst),
        .post        (post),
        .post_pri    (post_pri),
        .post_data   (post_data),
        .read        (read),
        .pending     (pending),
        .pending_pri (pending_pri),
        .out_valid   (out_valid),
        .out_data    (out_data),
        .out_pri     (out_pri),
        .overflow    (overflow),
        .drop_count  (drop_count),
        .errors      (mismatch_errors),
        .levels_read (levels_read),
        .drops_seen  (drops_seen)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // Phases move between filling, balanced traffic, draining and flooding.
    task automatic run_random(input int cycles);
        int post_pct;
        int read_pct;
        for (int c = 0; c < cycles; c++) begin
            case ((c / 200) % 4)
                0: begin
                    post_pct = 70;
                    read_pct = 20;
                end
                1: begin
                    post_pct = 40;
                    read_pct = 45;
                end
                2: begin
                    post_pct = 15;
                    read_pct = 85;
                end
                default: begin
                    post_pct = 95;
                    read_pct = 5;
                end
            endcase
            post      = ($urandom_range(99) < post_pct);
            post_pri  = pri_t'($urandom_range(`INTC_LEVELS - 1));
            post_data = data_t'($urandom);
            read      = ($urandom_range(99) < read_pct);
            @(posedge clk);
            #1;
        end
    endtask

    task automatic drain_queues();
        int waited;
        post   = 1'b0;
        read   = 1'b1;
        waited = 0;
        while (pending && waited < drain_limit) begin
            @(posedge clk);
            #1;
            waited++;
        end
        read = 1'b0;
        if (pending) begin
            timeout_errors++;
            $display("Timeout: queues still hold events after %0d read cycles", waited);
        end
        waited = 0;
        while (out_valid && waited < 4) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (out_valid) begin
            timeout_errors++;
            $display("Timeout: out_valid stayed high after the queues drained");
        end
        // Two falling edges let the checker see the idle outputs.
        repeat (2) @(negedge clk);
    endtask

    task automatic check_coverage();
        for (int i = 0; i < `INTC_LEVELS; i++) begin
            if (!levels_read[i]) begin
                coverage_errors++;
                $display("Coverage: no event was ever read from level %0d", i);
            end
        end
        if (drops_seen == 0) begin
            coverage_errors++;
            $display("Coverage: no post was ever dropped on a full queue");
        end
    endtask

    task automatic report_result();
        int assert_errors;
        int total;
        assert_errors = interrupt_controller_inst.intc_assert_inst.fail_count;
        total = mismatch_errors + assert_errors + timeout_errors + coverage_errors;
        $display("Errors: %0d mismatches, %0d assertion failures, %0d timeouts, %0d coverage gaps",
                 mismatch_errors, assert_errors, timeout_errors, coverage_errors);
        if (total == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    endtask

    initial begin
        int seed_val;
        seed_val        = $urandom(82685);
        rst             = 1'b1;
        post            = 1'b0;
        post_pri        = '0;
        post_data       = '0;
        read            = 1'b0;
        timeout_errors  = 0;
        coverage_errors = 0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        run_random(run_cycles);
        drain_queues();
        check_coverage();
        report_result();
    end

endmodule

`default_nettype wire

//--- interrupt_controller.f
+incdir+common
common/intc_pkg.sv
verilog/post_router.sv
prio_queue/prio_queue.sv
verilog/priority_dispatcher.sv
verilog/interrupt_controller.sv
verification/intc_checker.sv
verification/intc_assert.sv
verification/intc_tb.sv
